//--- list.f
lookahead_pkg.sv
sync_fifo.sv
lookahead_fifo.sv
req_ack_receiver.sv
pair_alu.sv
pair_stream_top.sv
pair_stream_assertions.sv
tb_pair_stream_top.sv

//--- tb_pair_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pair_stream_top
	import lookahead_pkg::*;
();

	localparam int WIDTH      = DATA_W;
	localparam int DEPTH      = 4;
	localparam int NUM_WORDS  = 48;
	localparam int HOLD_INDEX = 4;    // result whose ack is held off for a long time
	localparam int HOLD_LEN   = 300;
	localparam int TIMEOUT    = 1000;

	logic         clk;
	logic         rst_n;
	logic         in_req;
	pair_word_t   in_word;
	logic         in_ack;
	logic         out_req;
	pair_result_t out_result;
	logic         out_ack;

	logic [31:0]  rand_state = 32'hf963;
	pair_word_t   words [NUM_WORDS];
	int unsigned  src_gap [NUM_WORDS];
	int unsigned  ack_delay [NUM_WORDS];
	int unsigned  results_seen = 0;

	pair_stream_top #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_req     (in_req),
		.in_word    (in_word),
		.in_ack     (in_ack),
		.out_req    (out_req),
		.out_result (out_result),
		.out_ack    (out_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// reference for one pair from the opcode definitions
	function automatic pair_result_t model_pair(pair_word_t older, pair_word_t newer);
		pair_result_t r;
		int unsigned  a;
		int unsigned  b;
		int unsigned  m;
		a = older.data;
		b = newer.data;
		m = 1 << DATA_W;
		r.op = older.op;
		case (older.op)
			op_sum:  r.value = DATA_W'((a + b) % m);
			op_diff: r.value = DATA_W'((a + m - b) % m);
			default: r.value = (a >= b) ? DATA_W'(a) : DATA_W'(b);
		endcase
		return r;
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic wait_in_ack(input logic level);
		int unsigned n;
		n = 0;
		@(negedge clk);
		while (in_ack !== level) begin
			n++;
			if (n > TIMEOUT) begin
				fail_now($sformatf("timeout waiting for in_ack to become %0b", level));
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_out_req(input logic level);
		int unsigned n;
		n = 0;
		@(negedge clk);
		while (out_req !== level) begin
			n++;
			if (n > TIMEOUT) begin
				fail_now($sformatf("timeout waiting for out_req to become %0b", level));
			end
			@(negedge clk);
		end
	endtask

	// one four-phase transfer on the input channel
	task automatic send_word(input int idx);
		@(posedge clk);
		in_word <= words[idx];
		in_req  <= 1'b1;
		wait_in_ack(1'b1);
		@(posedge clk);
		in_req <= 1'b0;
		wait_in_ack(1'b0);
		repeat (src_gap[idx]) @(posedge clk);
	endtask

	task automatic take_result(input int idx);
		pair_result_t exp;
		exp = model_pair(words[idx], words[idx + 1]);
		wait_out_req(1'b1);
		assert (out_result.op === exp.op)
		else fail_now($sformatf("MISMATCH out_result.op expected %h got %h (result %0d)",
			exp.op, out_result.op, idx));
		assert (out_result.value === exp.value)
		else fail_now($sformatf("MISMATCH out_result.value expected %h got %h (result %0d)",
			exp.value, out_result.value, idx));
		if (idx == HOLD_INDEX) begin
			repeat (HOLD_LEN) @(negedge clk);
			// the source has words left, so it has to be stuck by now
			assert (in_req === 1'b1 && in_ack === 1'b0)
			else fail_now("in_ack did not stall while out_ack was held off");
		end else begin
			repeat (ack_delay[idx]) @(posedge clk);
		end
		@(posedge clk);
		out_ack <= 1'b1;
		wait_out_req(1'b0);
		@(posedge clk);
		out_ack <= 1'b0;
	endtask

	// every rising out_req is one result
	always @(posedge out_req) begin
		results_seen++;
	end

	// bound handshake and FIFO checks
	always @(negedge clk) begin
		assert (u_dut.u_checks.error_count == 0)
		else fail_now("a bound handshake or FIFO assertion fired");
	end

	initial begin
		rst_n   = 1'b0;
		in_req  = 1'b0;
		in_word = '0;
		out_ack = 1'b0;

		for (int k = 0; k < NUM_WORDS; k++) begin
			words[k].op   = pair_op_e'(2'((next_rand() >> 16) % 3));
			words[k].data = DATA_W'(next_rand() >> 16);
			src_gap[k]    = (next_rand() >> 16) % 4;   // zero means back to back
			ack_delay[k]  = (next_rand() >> 16) % 4;
		end

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		assert (in_ack === 1'b0)
		else fail_now($sformatf("MISMATCH in_ack expected %h got %h", 1'b0, in_ack));
		assert (out_req === 1'b0)
		else fail_now($sformatf("MISMATCH out_req expected %h got %h", 1'b0, out_req));

		// a single word has no partner yet
		send_word(0);
		repeat (20) begin
			@(negedge clk);
			assert (out_req === 1'b0)
			else fail_now("result appeared after only one word");
		end

		fork
			for (int k = 1; k < NUM_WORDS; k++) begin
				send_word(k);
			end
			for (int k = 0; k < NUM_WORDS - 1; k++) begin
				take_result(k);
			end
		join

		// the last word waits for a successor that never comes
		repeat (50) begin
			@(negedge clk);
			assert (out_req === 1'b0)
			else fail_now("extra result after the last pair");
		end
		assert (results_seen == NUM_WORDS - 1)
		else fail_now($sformatf("MISMATCH results_seen expected %h got %h",
			NUM_WORDS - 1, results_seen));

		if (u_dut.u_checks.error_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			fail_now("a bound handshake or FIFO assertion fired");
		end
	end

endmodule

`default_nettype wire

//--- pair_stream_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pair_stream_assertions (
	input wire clk,
	input wire rst_n,
	input wire in_req,
	input wire in_ack,
	input wire out_req,
	input wire out_ack,
	input wire push,
	input wire full,
	input wire pop,
	input wire head_valid
);

	// failed checks so far
	int unsigned error_count = 0;

	// a raised request is held until the sink answers
	out_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		out_req && !out_ack |=> out_req)
	else begin
		$error("out_req dropped before out_ack");
		error_count = error_count + 1;
	end

	in_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(in_ack) |-> in_req)
	else begin
		$error("in_ack rose while in_req was low");
		error_count = error_count + 1;
	end

	// a word is acknowledged only once it went into a body with room
	ack_after_push: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(in_ack) |-> $past(push) && !$past(full))
	else begin
		$error("in_ack rose without a push into a FIFO with room");
		error_count = error_count + 1;
	end

	// a popped pair refills the head and raises the output request
	pop_refills_head: assert property (@(posedge clk) disable iff (!rst_n)
		pop |=> head_valid && out_req)
	else begin
		$error("pop was not followed by a valid head and a raised out_req");
		error_count = error_count + 1;
	end

endmodule

bind pair_stream_top pair_stream_assertions u_checks (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_req     (in_req),
	.in_ack     (in_ack),
	.out_req    (out_req),
	.out_ack    (out_ack),
	.push       (push),
	.full       (full),
	.pop        (pop),
	.head_valid (head_valid)
);

`default_nettype wire

//--- pair_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module pair_stream_top
	import lookahead_pkg::*;
#(
	parameter int WIDTH = 16,
	parameter int DEPTH = 4
) (
	input  wire          clk,
	input  wire          rst_n,
	input  wire          in_req,
	input  wire          pair_word_t in_word,
	output logic         in_ack,
	output logic         out_req,
	output pair_result_t out_result,
	input  wire          out_ack
);

	logic       push;
	pair_word_t push_word;
	pair_word_t head_word;
	pair_word_t next_word;
	logic       head_valid;
	logic       next_valid;
	logic       full;
	logic       pop;

	// word and result structs are sized by the package width
	if (WIDTH != DATA_W) begin : g_width_check
		$error("pair_stream_top: WIDTH %0d differs from DATA_W %0d", WIDTH, DATA_W);
	end

	req_ack_receiver u_receiver (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_req    (in_req),
		.in_word   (in_word),
		.in_ack    (in_ack),
		.full      (full),
		.push      (push),
		.push_word (push_word)
	);

	lookahead_fifo #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.pop        (pop),
		.push_word  (push_word),
		.head_word  (head_word),
		.head_valid (head_valid),
		.next_word  (next_word),
		.next_valid (next_valid),
		.full       (full)
	);

	pair_alu #(
		.WIDTH (WIDTH)
	) u_alu (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_word  (head_word),
		.head_valid (head_valid),
		.next_word  (next_word),
		.next_valid (next_valid),
		.pop        (pop),
		.out_req    (out_req),
		.out_result (out_result),
		.out_ack    (out_ack)
	);

endmodule

`default_nettype wire

//--- pair_alu.sv
`timescale 1ns/1ps
`default_nettype none

module pair_alu
	import lookahead_pkg::*;
#(
	parameter int WIDTH = 16
) (
	input  wire          clk,
	input  wire          rst_n,
	input  wire          pair_word_t head_word,
	input  wire          head_valid,
	input  wire          pair_word_t next_word,
	input  wire          next_valid,
	output logic         pop,
	output logic         out_req,
	output pair_result_t out_result,
	input  wire          out_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_req_high,
		st_wait_ack_low
	} alu_state_e;

	alu_state_e       state;
	pair_op_e         op;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;
	logic [WIDTH-1:0] value;

	assign op = head_word.op;    // the older word picks the operation
	assign a  = head_word.data;
	assign b  = next_word.data;

	// only take a pair when the output channel is free
	assign pop = (state == st_idle) && head_valid && next_valid;

	always_comb begin
		case (op)
			op_sum:  value = a + b;           // wraps mod 2**WIDTH
			op_diff: value = a - b;           // head minus next
			op_max:  value = (a > b) ? a : b; // unsigned compare
			default: value = '0;
		endcase
	end

	// result register, loaded on the pop
	always_ff @(posedge clk) begin
		if (pop) begin
			out_result.op    <= op;
			out_result.value <= value;
		end
	end

	// four-phase output handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			out_req <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (pop) begin
						state   <= st_req_high;
						out_req <= 1'b1;
					end
				end
				st_req_high: begin
					if (out_ack) begin
						state   <= st_wait_ack_low;
						out_req <= 1'b0;
					end
				end
				st_wait_ack_low: begin
					if (!out_ack) begin  // sink has released, next pair may go
						state <= st_idle;
					end
				end
				default: begin
					state   <= st_idle;
					out_req <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- req_ack_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module req_ack_receiver
	import lookahead_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        in_req,
	input  wire        pair_word_t in_word,
	output logic       in_ack,
	input  wire        full,
	output logic       push,
	output pair_word_t push_word
);

	typedef enum logic [1:0] {
		st_idle,
		st_taken,
		st_wait_low
	} rx_state_e;

	rx_state_e state;

	// exactly one push per request, held off while the fifo is full
	assign push      = (state == st_idle) && in_req && !in_ack && !full;
	assign push_word = in_word;  // stable while req is up

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= st_idle;
			in_ack <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (push) begin
						state  <= st_taken;
						in_ack <= 1'b1;
					end
				end
				st_taken: begin
					if (!in_req) begin  // source has seen the ack
						state  <= st_wait_low;
						in_ack <= 1'b0;
					end
				end
				st_wait_low: state <= st_idle;
				default:     state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lookahead_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lookahead_fifo
	import lookahead_pkg::*;
#(
	parameter int WIDTH = 16,
	parameter int DEPTH = 4
) (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        push,
	input  wire        pop,
	input  wire        pair_word_t push_word,
	output pair_word_t head_word,
	output logic       head_valid,
	output pair_word_t next_word,
	output logic       next_valid,
	output logic       full
);

	localparam int WORD_W = $bits(pair_op_e) + WIDTH;

	logic              head_empty;
	logic              body_empty;
	logic              to_head;
	logic              head_push;
	logic              body_push;
	logic              body_pop;
	logic [WORD_W-1:0] head_wdata;
	logic [WORD_W-1:0] head_rdata;
	logic [WORD_W-1:0] body_rdata;

	// the head slot never holds more than one word
	always_comb begin
		// new word lands in the head when nothing would be in front of it
		to_head   = head_empty || (pop && body_empty);
		body_pop  = pop && !body_empty;
		head_push = (push && to_head) || body_pop;
		body_push = push && !to_head;

		// refill from the body wins, the two cases never overlap
		if (body_pop) begin
			head_wdata = body_rdata;
		end else begin
			head_wdata = push_word;
		end
	end

	sync_fifo #(
		.WIDTH (WORD_W),
		.DEPTH (DEPTH)
	) u_head (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (head_push),
		.pop     (pop),
		.wr_data (head_wdata),
		.rd_data (head_rdata),
		.empty   (head_empty),
		.full    ()
	);

	sync_fifo #(
		.WIDTH (WORD_W),
		.DEPTH (DEPTH)
	) u_body (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (body_push),
		.pop     (body_pop),
		.wr_data (push_word),
		.rd_data (body_rdata),
		.empty   (body_empty),
		.full    (full)       // back-pressure comes from the body only
	);

	assign head_word  = head_rdata;
	assign head_valid = !head_empty;
	assign next_word  = body_rdata;  // oldest body entry is the word behind the head
	assign next_valid = !body_empty;

endmodule

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 18,
	parameter int DEPTH = 4
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              push,
	input  wire              pop,
	input  wire  [WIDTH-1:0] wr_data,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty,
	output logic             full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;

	// wrap at DEPTH, so DEPTH need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_pop  = pop && !empty;            // pop on empty is ignored
	assign do_push = push && (!full || do_pop); // a full fifo takes a word only with a pop

	assign empty   = (count == '0);
	assign full    = (count == CW'(DEPTH));
	assign rd_data = mem[rd_ptr];               // oldest entry, no pop needed to see it

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
		end
	end

	// occupancy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lookahead_pkg.sv
`default_nettype none

package lookahead_pkg;

	// value width, the top level parameter WIDTH has to agree with it
	localparam int DATA_W = 16;

	// pairwise operations, 2'b11 is unused
	typedef enum logic [1:0] {
		op_sum  = 2'd0,
		op_diff = 2'd1,
		op_max  = 2'd2
	} pair_op_e;

	// one input word as it travels through receiver and fifo
	typedef struct packed {
		pair_op_e          op;
		logic [DATA_W-1:0] data;
	} pair_word_t;

	// one result on the output channel, op is the opcode of the older word
	typedef struct packed {
		pair_op_e          op;
		logic [DATA_W-1:0] value;
	} pair_result_t;

endpackage

`default_nettype wire
